// ==== project.f ====
rtl/mem_probe_pkg.sv
rtl/poll_timebase.sv
rtl/mem_poller.sv
rtl/hex_display.sv
rtl/mem_probe_top.sv
tests/data_mem_model.sv
tests/mem_probe_tb.sv

// ==== tests/mem_probe_tb.sv ====
// testbench for mem_probe_top with data memory model, checkers and timeout
`timescale 1ns/1ps

module mem_probe_tb
  import mem_probe_pkg::*;
;

  localparam int hb_cycles      = 20;                  // short heartbeat for sim
  localparam int rst_cycles     = 16;
  localparam int n_polls        = 40;
  localparam int poll_len       = 5;                   // phases per poll
  localparam int timeout_cycles = 2 * n_polls * poll_len;

  logic              check_mem_FPGA = 1'b0;
  logic              hps_fpga_reset_n;
  logic [word_w-1:0] data_mem_readdata;
  logic              data_mem_chipselect;
  logic              instr_mem_chipselect;
  logic              instr_mem_write;
  logic              heartbeat_led;
  logic [seg_w-1:0]  hex_bus [n_digits];               // hex0..hex5
  logic [word_w-1:0] mem_word;                         // word the model returns

  logic [31:0]       lcg_state = 32'h61aa;
  logic [disp_w-1:0] exp_words [$];                    // low bits, one per poll
  logic [disp_w-1:0] exp_disp = '0;                    // value the displays should show
  int                rel_n = 0;                        // cycles since reset release
  int                total_cyc = 0;
  int                captures = 0;
  int                value_errors = 0;
  int                other_errors = 0;
  logic              prev_dcs = 1'b0;                  // select seen last cycle
  logic              prev_imw = 1'b0;                  // write seen last cycle

  always #2 check_mem_FPGA = ~check_mem_FPGA;          // 4 ns period

  // ====================================================================
  // DUT and memory model
  // ====================================================================
  mem_probe_top #(
    .heartbeat_cycles (hb_cycles)
  ) UUT (
    .check_mem_FPGA       (check_mem_FPGA),
    .hps_fpga_reset_n     (hps_fpga_reset_n),
    .data_mem_readdata    (data_mem_readdata),
    .data_mem_chipselect  (data_mem_chipselect),
    .instr_mem_chipselect (instr_mem_chipselect),
    .instr_mem_write      (instr_mem_write),
    .heartbeat_led        (heartbeat_led),
    .hex0                 (hex_bus[0]),
    .hex1                 (hex_bus[1]),
    .hex2                 (hex_bus[2]),
    .hex3                 (hex_bus[3]),
    .hex4                 (hex_bus[4]),
    .hex5                 (hex_bus[5])
  );

  data_mem_model u_data_mem (
    .check_mem_FPGA   (check_mem_FPGA),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .chipselect       (data_mem_chipselect),
    .word             (mem_word),
    .readdata         (data_mem_readdata)
  );

  // ====================================================================
  // helpers
  // ====================================================================
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // 32-bit LCG
    return lcg_state;
  endfunction

  // active low glyph built from the lit segments, bit 0 = a
  function automatic logic [seg_w-1:0] expected_glyph(input logic [3:0] nib);
    string            lit;
    logic [seg_w-1:0] seg;
    int               i;
    case (nib)
      4'h0: lit = "abcdef";
      4'h1: lit = "bc";
      4'h2: lit = "abdeg";
      4'h3: lit = "abcdg";
      4'h4: lit = "bcfg";
      4'h5: lit = "acdfg";
      4'h6: lit = "acdefg";
      4'h7: lit = "abc";
      4'h8: lit = "abcdefg";
      4'h9: lit = "abcdfg";
      4'ha: lit = "abcefg";
      4'hb: lit = "cdefg";                             // lower case b
      4'hc: lit = "adef";
      4'hd: lit = "bcdeg";                             // lower case d
      4'he: lit = "adefg";
      default: lit = "aefg";
    endcase
    seg = '1;
    for (i = 0; i < lit.len(); i++)
      seg[lit[i] - 8'd97] = 1'b0;                      // lit segment driven low
    return seg;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("CHECK FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
    value_errors++;
  endtask

  task automatic report_problem(input string what);
    $display("error: %s at %0t", what, $time);
    other_errors++;
  endtask

  task automatic load_word();
    logic [word_w-1:0] w;
    w = next_random();
    mem_word = w;
    exp_words.push_back(w[disp_w-1:0]);                // only 24 bits reach the display
  endtask

  task automatic end_run();
    $display("errors: value %0d, other %0d, captures %0d of %0d",
             value_errors, other_errors, captures, n_polls);
    if (value_errors != 0 || other_errors != 0)
    begin
      $display("TB FAILED");
    end
    else
    begin
      $display("TB PASSED");
    end
    $finish;
  endtask

  // ====================================================================
  // checkers, sampled mid-cycle
  // ====================================================================
  always @(posedge check_mem_FPGA)
  begin
    if (hps_fpga_reset_n)
      rel_n <= rel_n + 1;                              // cycle 0 starts at release
  end

  always @(negedge check_mem_FPGA)
  begin
    if (!hps_fpga_reset_n)
    begin
      assert (data_mem_chipselect == 1'b0) else report_mismatch("reset", 0, data_mem_chipselect);
      assert (instr_mem_chipselect == 1'b0) else report_mismatch("reset", 0, instr_mem_chipselect);
      assert (instr_mem_write == 1'b0) else report_mismatch("reset", 0, instr_mem_write);
      assert (heartbeat_led == 1'b0) else report_mismatch("reset", 0, heartbeat_led);
    end
    else
    begin
      // prep on cycle 3, then every poll_len cycles
      assert (data_mem_chipselect == (rel_n >= 3 && (rel_n - 3) % poll_len == 0))
        else report_mismatch("read_cadence", rel_n >= 3 && (rel_n - 3) % poll_len == 0,
                             data_mem_chipselect);
      assert (!(data_mem_chipselect && prev_dcs))
        else report_problem("data memory select high two cycles in a row");
      assert (instr_mem_chipselect == instr_mem_write)
        else report_mismatch("instr_write", instr_mem_chipselect, instr_mem_write);
      assert (instr_mem_write == prev_dcs)              // exactly one after each read
        else report_mismatch("instr_write", prev_dcs, instr_mem_write);
      assert (heartbeat_led == ((rel_n / hb_cycles) % 2 == 1))
        else report_mismatch("heartbeat", (rel_n / hb_cycles) % 2, heartbeat_led);
      if (prev_imw)
      begin
        if (captures < exp_words.size())
          exp_disp = exp_words[captures];              // word loaded for this poll
        else
          report_problem("capture with no word loaded for it");
        captures++;
      end
    end
    for (int k = 0; k < n_digits; k++)
    begin
      assert (hex_bus[k] == expected_glyph(exp_disp[k*4 +: 4]))
        else report_mismatch("display", expected_glyph(exp_disp[k*4 +: 4]), hex_bus[k]);
    end
    prev_dcs = hps_fpga_reset_n && data_mem_chipselect;
    prev_imw = hps_fpga_reset_n && instr_mem_write;
  end

  // run limit, a stuck strobe never lets the poll loop finish
  always @(posedge check_mem_FPGA)
  begin
    total_cyc++;
    if (total_cyc >= rst_cycles + timeout_cycles)
    begin
      report_problem("timeout, instruction write strobes stopped arriving");
      end_run();
    end
  end

  // ====================================================================
  // stimulus
  // ====================================================================
  initial
  begin
    hps_fpga_reset_n = 1'b0;
    mem_word         = '0;
    load_word();                                       // word for the first poll
    repeat (rst_cycles) @(posedge check_mem_FPGA);
    #1 hps_fpga_reset_n = 1'b1;
    for (int p = 0; p < n_polls; p++)
    begin
      @(negedge check_mem_FPGA);
      while (!instr_mem_write)
        @(negedge check_mem_FPGA);                     // wait for the check phase
      @(posedge check_mem_FPGA);
      #1;
      if (p < n_polls - 1)
        load_word();                                   // ready before the next prep
    end
    repeat (2) @(negedge check_mem_FPGA);
    @(posedge check_mem_FPGA);
    if (captures != n_polls)
      report_problem("number of display captures differs from number of polls");
    end_run();
  end

endmodule

// ==== tests/data_mem_model.sv ====
// behavioral data memory, one-cycle registered read of a testbench-set word
`timescale 1ns/1ps

module data_mem_model
  import mem_probe_pkg::*;
(
  input  logic              check_mem_FPGA,    // fabric clock
  input  logic              hps_fpga_reset_n,  // async, active low
  input  logic              chipselect,        // read select from the DUT
  input  logic [word_w-1:0] word,              // word the testbench loads
  output logic [word_w-1:0] readdata           // answer, one clock after select
);

  // single location, address is tied to 0 outside the DUT
  always_ff @(posedge check_mem_FPGA or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      readdata <= '0;
    end
    else if (chipselect)
    begin
      readdata <= word;                        // registered read
    end
    else
    begin
      readdata <= ~word;                       // bus not valid outside the answer cycle
    end
  end

endmodule

// ==== rtl/mem_probe_top.sv ====
// top level wiring timebase, memory poller and hex display to the board pins
`timescale 1ns/1ps

module mem_probe_top
  import mem_probe_pkg::*;
#(
  parameter int heartbeat_cycles = 25_000_000      // 0.5 s at 50 MHz
)
(
  input  logic              check_mem_FPGA,        // fabric clock
  input  logic              hps_fpga_reset_n,      // async, active low
  input  logic [word_w-1:0] data_mem_readdata,     // from on-chip data memory
  output logic              data_mem_chipselect,   // data memory read select
  output logic              instr_mem_chipselect,  // instruction memory select
  output logic              instr_mem_write,       // instruction memory write
  output logic              heartbeat_led,         // alive indicator
  output logic [seg_w-1:0]  hex0,                  // active low segments
  output logic [seg_w-1:0]  hex1,
  output logic [seg_w-1:0]  hex2,
  output logic [seg_w-1:0]  hex3,
  output logic [seg_w-1:0]  hex4,
  output logic [seg_w-1:0]  hex5
);

  // ====================================================================
  // internal nets
  // ====================================================================
  logic              prep_strobe;                  // timebase -> poller
  logic              check_strobe;                 // timebase -> poller
  logic [disp_w-1:0] disp_value;                   // poller -> display

  // ====================================================================
  // timebase, heartbeat and poll phases
  // ====================================================================
  poll_timebase #(
    .heartbeat_cycles (heartbeat_cycles)
  ) u_timebase (
    .check_mem_FPGA   (check_mem_FPGA),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .heartbeat_led    (heartbeat_led),
    .prep_strobe      (prep_strobe),
    .check_strobe     (check_strobe)
  );

  // ====================================================================
  // memory controls and capture
  // ====================================================================
  mem_poller u_poller (
    .check_mem_FPGA       (check_mem_FPGA),
    .hps_fpga_reset_n     (hps_fpga_reset_n),
    .prep_strobe          (prep_strobe),
    .check_strobe         (check_strobe),
    .data_mem_readdata    (data_mem_readdata),
    .data_mem_chipselect  (data_mem_chipselect),
    .instr_mem_chipselect (instr_mem_chipselect),
    .instr_mem_write      (instr_mem_write),
    .disp_value           (disp_value)
  );

  // ====================================================================
  // seven-segment decode
  // ====================================================================
  hex_display u_display (
    .disp_value (disp_value),
    .hex0       (hex0),
    .hex1       (hex1),
    .hex2       (hex2),
    .hex3       (hex3),
    .hex4       (hex4),
    .hex5       (hex5)
  );

endmodule

// ==== rtl/hex_display.sv ====
// six-digit hex decode of the display register to active-low segment outputs
`timescale 1ns/1ps

module hex_display
  import mem_probe_pkg::*;
(
  input  logic [disp_w-1:0] disp_value,      // six nibbles, digit 0 in 3..0
  output logic [seg_w-1:0]  hex0,            // rightmost display
  output logic [seg_w-1:0]  hex1,
  output logic [seg_w-1:0]  hex2,
  output logic [seg_w-1:0]  hex3,
  output logic [seg_w-1:0]  hex4,
  output logic [seg_w-1:0]  hex5             // leftmost display
);

  // ====================================================================
  // per digit decode
  // ====================================================================
  logic [nib_w-1:0] nib [n_digits];          // split register
  logic [seg_w-1:0] seg [n_digits];          // decoded, active low

  for (genvar k = 0; k < n_digits; k++)
  begin : g_digit
    assign nib[k] = disp_value[k*nib_w +: nib_w];   // nibble k -> display k
    assign seg[k] = hex_to_seg(nib[k]);             // 0..F glyphs
  end

  // purely combinational, follows disp_value in the same cycle
  assign hex0 = seg[0];
  assign hex1 = seg[1];
  assign hex2 = seg[2];
  assign hex3 = seg[3];
  assign hex4 = seg[4];
  assign hex5 = seg[5];

endmodule

// ==== rtl/mem_poller.sv ====
// memory select/write controls and the 24-bit display capture register
`timescale 1ns/1ps

module mem_poller
  import mem_probe_pkg::*;
(
  input  logic              check_mem_FPGA,        // fabric clock
  input  logic              hps_fpga_reset_n,      // async, active low
  input  logic              prep_strobe,           // read this cycle
  input  logic              check_strobe,          // capture this cycle
  input  logic [word_w-1:0] data_mem_readdata,     // word for the last prep
  output logic              data_mem_chipselect,   // data memory read select
  output logic              instr_mem_chipselect,  // instruction memory select
  output logic              instr_mem_write,       // instruction memory write
  output logic [disp_w-1:0] disp_value             // value shown on the displays
);

  // ====================================================================
  // memory side controls
  // ====================================================================
  // Both memories sit at a fixed address with clock enable and byte
  // enables tied outside, so only select and write come from here.
  // The data memory answers one clock after its select, which lines
  // the returned word up with the check phase that follows prep.

  assign data_mem_chipselect  = prep_strobe;       // read, address tied 0
  assign instr_mem_chipselect = check_strobe;      // same cycle as capture
  assign instr_mem_write      = check_strobe;      // write data tied outside

  // ====================================================================
  // display register
  // ====================================================================
  logic [disp_w-1:0] disp_q;                       // captured low bits
  logic [disp_w-1:0] disp_d;                       // next value

  // hold unless this is the check cycle
  always_comb
  begin
    if (check_strobe)
      disp_d = data_mem_readdata[disp_w-1:0];      // upper byte not shown
    else
      disp_d = disp_q;
  end

  // cleared so the displays read all zeros out of reset
  always_ff @(posedge check_mem_FPGA or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      disp_q <= '0;
    end
    else
    begin
      disp_q <= disp_d;                            // loads at end of check
    end
  end

  assign disp_value = disp_q;                      // to hex_display

endmodule

// ==== rtl/poll_timebase.sv ====
// heartbeat LED divider and five-phase poll sequencer with prep/check strobes
`timescale 1ns/1ps

module poll_timebase
  import mem_probe_pkg::*;
#(
  parameter int heartbeat_cycles = 25_000_000    // clocks between LED toggles
)
(
  input  logic check_mem_FPGA,                   // fabric clock
  input  logic hps_fpga_reset_n,                 // async, active low
  output logic heartbeat_led,                    // toggles on divider wrap
  output logic prep_strobe,                      // one cycle, ph_prep
  output logic check_strobe                      // one cycle, ph_check
);

  localparam int cnt_w = (heartbeat_cycles > 1) ? $clog2(heartbeat_cycles) : 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(heartbeat_cycles - 1);

  // ====================================================================
  // heartbeat divider
  // ====================================================================
  logic [cnt_w-1:0] hb_count;                    // free running, wraps at cnt_last

  always_ff @(posedge check_mem_FPGA or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      hb_count      <= '0;
      heartbeat_led <= 1'b0;                     // LED off out of reset
    end
    else if (hb_count == cnt_last)
    begin
      hb_count      <= '0;                       // wrap
      heartbeat_led <= ~heartbeat_led;           // one toggle per period
    end
    else
    begin
      hb_count <= hb_count + 1'b1;
    end
  end

  // ====================================================================
  // poll phase sequencer
  // ====================================================================
  poll_phase_t phase;                            // current poll phase
  poll_phase_t phase_nxt;

  // idle0 -> idle1 -> idle2 -> prep -> check -> idle0
  always_comb
  begin
    case (phase)
      ph_idle0: phase_nxt = ph_idle1;
      ph_idle1: phase_nxt = ph_idle2;
      ph_idle2: phase_nxt = ph_prep;
      ph_prep:  phase_nxt = ph_check;
      default:  phase_nxt = ph_idle0;            // check and illegal codes
    endcase
  end

  always_ff @(posedge check_mem_FPGA or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
      phase <= ph_idle0;                         // first prep 3 clocks after release
    else
      phase <= phase_nxt;                        // one step every clock
  end

  // strobes decoded straight from the phase register
  assign prep_strobe  = (phase == ph_prep);
  assign check_strobe = (phase == ph_check);

endmodule

// ==== rtl/mem_probe_pkg.sv ====
// widths, poll phase enum, tied memory port values and the hex to segment decode
package mem_probe_pkg;

  // ====================================================================
  // widths
  // ====================================================================
  localparam int word_w   = 32;          // memory word
  localparam int disp_w   = 24;          // display register, six nibbles
  localparam int nib_w    = 4;           // one hex digit
  localparam int n_digits = 6;           // seven-segment displays on the board
  localparam int seg_w    = 7;           // segments a..g per display

  // ====================================================================
  // poll sequence
  // ====================================================================
  typedef enum logic [2:0] {
    ph_idle0 = 3'd0,                     // quiet
    ph_idle1 = 3'd1,                     // quiet
    ph_idle2 = 3'd2,                     // quiet
    ph_prep  = 3'd3,                     // data memory read select
    ph_check = 3'd4                      // capture + instruction write
  } poll_phase_t;

  // memory side ties, held constant by the memory wrapper
  localparam logic [word_w-1:0]   instr_word      = word_w'(100);  // instr write data
  localparam logic [9:0]          tied_address    = 10'd0;         // both memories
  localparam logic [word_w/8-1:0] tied_byteenable = '1;            // all lanes on

  // active low segments, bit 0 = a .. bit 6 = g
  function automatic logic [seg_w-1:0] hex_to_seg(input logic [nib_w-1:0] nib);
    logic [seg_w-1:0] seg;
    case (nib)
      4'h0: seg = 7'h40;
      4'h1: seg = 7'h79;
      4'h2: seg = 7'h24;
      4'h3: seg = 7'h30;
      4'h4: seg = 7'h19;
      4'h5: seg = 7'h12;
      4'h6: seg = 7'h02;
      4'h7: seg = 7'h78;
      4'h8: seg = 7'h00;
      4'h9: seg = 7'h10;
      4'ha: seg = 7'h08;
      4'hb: seg = 7'h03;                 // lower case b
      4'hc: seg = 7'h46;
      4'hd: seg = 7'h21;                 // lower case d
      4'he: seg = 7'h06;
      default: seg = 7'h0e;              // F
    endcase
    return seg;
  endfunction

endpackage
